//--- common/ic_consts.svh
////////////////////////////////////////////////////////////
// Instruction cache geometry constants
// Four ways, 64 sets, 16-byte lines of 32-bit words
////////////////////////////////////////////////////////////
`ifndef IC_CONSTS_SVH
`define IC_CONSTS_SVH

// Associativity
`define IC_NUM_WAYS 4

// Set index width, gives 64 sets
`define IC_INDEX_BITS 6

// Instruction word width
`define IC_WORD_BITS 32

// Fetch address width, byte address
`define IC_ADDR_BITS 32

// Byte offset inside one 16-byte line
`define IC_OFFSET_BITS 4

`endif

//--- common/ic_addr_pkg.sv
////////////////////////////////////////////////////////////
// Instruction cache address field types
// Splits a fetch word address into tag, index and word select
////////////////////////////////////////////////////////////
`include "ic_consts.svh"

package ic_addr_pkg;

   localparam int BYTE_BITS = 2;                       // Byte within a word, not carried
   localparam int WSEL_BITS = `IC_OFFSET_BITS - BYTE_BITS;
   localparam int TAG_BITS  = `IC_ADDR_BITS - `IC_INDEX_BITS - `IC_OFFSET_BITS;

   typedef logic [TAG_BITS-1:0]       ic_tag_t;        // Address bits 31:10
   typedef logic [`IC_INDEX_BITS-1:0] ic_index_t;      // Address bits 9:4
   typedef logic [WSEL_BITS-1:0]      ic_word_sel_t;   // Address bits 3:2

   // Word address as seen by the arrays, MSB first
   typedef struct packed {
      ic_tag_t      tag;
      ic_index_t    index;
      ic_word_sel_t word_sel;
   } ic_addr_t;

endpackage

//--- common/ic_entry_pkg.sv
////////////////////////////////////////////////////////////
// Instruction cache stored entry and per-way vector types
////////////////////////////////////////////////////////////
`include "ic_consts.svh"

package ic_entry_pkg;

   // Tag entry with even parity on top
   typedef struct packed {
      logic                 parity;
      ic_addr_pkg::ic_tag_t tag;
   } ic_tag_entry_t;

   typedef logic [`IC_WORD_BITS-1:0] ic_word_t;
   typedef logic [`IC_NUM_WAYS-1:0]  ic_way_vec_t;    // One bit per way
   typedef ic_word_t [`IC_NUM_WAYS-1:0] ic_way_words_t;

   // Build a fill entry, parity makes the total bit count even
   function automatic ic_tag_entry_t make_tag_entry(ic_addr_pkg::ic_tag_t tag);
      ic_tag_entry_t entry;
      entry.parity = ^tag;
      entry.tag    = tag;
      return entry;
   endfunction

   function automatic logic tag_entry_perr(ic_tag_entry_t entry);
      return ^{entry.parity, entry.tag};               // Odd count means error
   endfunction

endpackage

//--- common/ic_lookup_if.sv
////////////////////////////////////////////////////////////
// Per-way lookup results from the tag and data arrays
// Valid in the cycle after a read request
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

interface ic_lookup_if (
   input logic clk
);

   import ic_entry_pkg::*;

   ic_way_vec_t   way_hit;                             // Stored tag matches request
   ic_way_vec_t   way_perr;                            // Stored tag parity bad
   ic_way_words_t way_words;                           // Word read from each way

   // Tag side
   modport tag_src (
      output way_hit,
      output way_perr
   );

   // Data side
   modport data_src (
      output way_words
   );

   // Way select reads everything, clock is for its checks
   modport sel (
      input clk,
      input way_hit,
      input way_perr,
      input way_words
   );

endinterface

//--- design/ic_sram.sv
////////////////////////////////////////////////////////////
// Synchronous single-port memory, registered read
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ic_sram #(
   parameter type ENTRY_T = logic,
   parameter int  DEPTH   = 64
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  ENTRY_T                   din,
   output ENTRY_T                   dout
);

   ENTRY_T mem [0:DEPTH-1];

   ////////////////////////////////////////////////////////////
   // Array access
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= din;                             // Write lands at the edge
      end
      dout <= mem[addr];                               // Old contents on a write cycle
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // A write to an unknown row would corrupt the whole array in silicon
   a_wr_addr_known : assert property (
      @(posedge clk) we |-> !$isunknown(addr)
   ) else $error("ic_sram write with unknown address");

endmodule

//--- ic_tag/ic_tag_array.sv
////////////////////////////////////////////////////////////
// Instruction cache tag array, four ways
// Fill and debug writes, hit compare and parity check
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "ic_consts.svh"

module ic_tag_array (
   input  logic                        clk,
   input  logic                        arst_n,
   input  ic_addr_pkg::ic_addr_t       rw_addr,
   input  logic                        rd_en,
   input  ic_entry_pkg::ic_way_vec_t   wr_en,
   input  logic                        debug_wr_en,
   input  ic_entry_pkg::ic_way_vec_t   debug_way,
   input  ic_entry_pkg::ic_tag_entry_t debug_wr_data,
   ic_lookup_if.tag_src                lookup
);

   import ic_addr_pkg::*;
   import ic_entry_pkg::*;

   localparam int TAG_DEPTH = 1 << `IC_INDEX_BITS;

   logic                                 last_word;
   ic_way_vec_t                          tag_wr_en;
   ic_tag_entry_t                        tag_wr_data;
   ic_tag_t                              cmp_tag;
   ic_tag_entry_t [`IC_NUM_WAYS-1:0]     tag_rd;
   ic_way_vec_t                          way_hit;
   ic_way_vec_t                          way_perr;

   ////////////////////////////////////////////////////////////
   // Write decision
   ////////////////////////////////////////////////////////////

   // Tag goes in with the final beat, so a partial line never hits
   assign last_word = (rw_addr.word_sel == '1);

   assign tag_wr_en = (wr_en & {`IC_NUM_WAYS{last_word}}) |
                      (debug_way & {`IC_NUM_WAYS{debug_wr_en}});

   // Debug entry is stored raw, parity included
   assign tag_wr_data = debug_wr_en ? debug_wr_data : make_tag_entry(rw_addr.tag);

   ////////////////////////////////////////////////////////////
   // Compare tag
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rd_en) begin
         cmp_tag <= rw_addr.tag;                       // Lines up with SRAM output
      end
   end

   ////////////////////////////////////////////////////////////
   // Ways
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `IC_NUM_WAYS; i++) begin : g_way

      ic_sram #(
         .ENTRY_T (ic_tag_entry_t),
         .DEPTH   (TAG_DEPTH)
      ) u_tag_sram (
         .clk  (clk),
         .we   (tag_wr_en[i]),
         .addr (rw_addr.index),
         .din  (tag_wr_data),
         .dout (tag_rd[i])
      );

      assign way_hit[i]  = (tag_rd[i].tag == cmp_tag);
      assign way_perr[i] = tag_entry_perr(tag_rd[i]);  // Valid qualify done later

   end

   assign lookup.way_hit  = way_hit;
   assign lookup.way_perr = way_perr;

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // A fill targets a single way, else the set holds duplicate tags
   a_fill_way_onehot : assert property (
      @(posedge clk) disable iff (!arst_n) $onehot0(wr_en)
   ) else $error("ic_tag_array fill way not one-hot: %h", wr_en);

endmodule

//--- ic_data/ic_data_array.sv
////////////////////////////////////////////////////////////
// Instruction cache data array, four ways
// Each way holds one word per set and word select
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "ic_consts.svh"

module ic_data_array (
   input  logic                      clk,
   input  ic_addr_pkg::ic_addr_t     rw_addr,
   input  ic_entry_pkg::ic_way_vec_t wr_en,
   input  ic_entry_pkg::ic_word_t    wr_data,
   ic_lookup_if.data_src             lookup
);

   import ic_addr_pkg::*;
   import ic_entry_pkg::*;

   localparam int ROW_BITS   = `IC_INDEX_BITS + $bits(ic_word_sel_t);
   localparam int DATA_DEPTH = 1 << ROW_BITS;          // 256 words per way

   logic [ROW_BITS-1:0] row_addr;
   ic_way_words_t       way_words;

   ////////////////////////////////////////////////////////////
   // Row address
   ////////////////////////////////////////////////////////////

   // Set in the upper bits, words of a line sit next to each other
   assign row_addr = {rw_addr.index, rw_addr.word_sel};

   ////////////////////////////////////////////////////////////
   // Ways
   ////////////////////////////////////////////////////////////

   for (genvar i = 0; i < `IC_NUM_WAYS; i++) begin : g_way

      ic_sram #(
         .ENTRY_T (ic_word_t),
         .DEPTH   (DATA_DEPTH)
      ) u_data_sram (
         .clk  (clk),
         .we   (wr_en[i]),                             // One beat per word
         .addr (row_addr),
         .din  (wr_data),
         .dout (way_words[i])
      );

   end

   // All ways read in parallel, the hit picks one later
   assign lookup.way_words = way_words;

endmodule

//--- design/ic_way_select.sv
////////////////////////////////////////////////////////////
// Way select, merges tag and data results into a response
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "ic_consts.svh"

module ic_way_select (
   input  ic_entry_pkg::ic_way_vec_t tag_valid,
   ic_lookup_if.sel                  lookup,
   output ic_entry_pkg::ic_way_vec_t rd_hit,
   output ic_entry_pkg::ic_word_t    rd_data,
   output logic                      tag_perr
);

   import ic_entry_pkg::*;

   ////////////////////////////////////////////////////////////
   // Hit and data
   ////////////////////////////////////////////////////////////

   assign rd_hit = lookup.way_hit & tag_valid;         // Invalid ways never hit

   // AND-OR mux, zero when nothing hits
   always_comb begin
      ic_word_t data_or;
      data_or = '0;
      for (int i = 0; i < `IC_NUM_WAYS; i++) begin
         data_or = data_or | ({`IC_WORD_BITS{rd_hit[i]}} & lookup.way_words[i]);
      end
      rd_data = data_or;
   end

   // Parity of an invalid way is stale and ignored
   assign tag_perr = |(lookup.way_perr & tag_valid);

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   // Fill control must never leave one tag valid in two ways of a set
   a_hit_onehot : assert property (
      @(posedge lookup.clk) !$isunknown(rd_hit) |-> $onehot0(rd_hit)
   ) else $error("ic_way_select multiple way hit: %h", rd_hit);

endmodule

//--- design/ifu_ic_mem.sv
////////////////////////////////////////////////////////////
// Instruction cache memory top, tag and data arrays
// with way select and the read response valid
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ifu_ic_mem (
   input  logic                        clk,
   input  logic                        arst_n,
   input  ic_addr_pkg::ic_addr_t       rw_addr,
   input  logic                        rd_en,
   input  ic_entry_pkg::ic_way_vec_t   wr_en,        // One-hot fill way
   input  ic_entry_pkg::ic_word_t      wr_data,
   input  logic                        debug_wr_en,
   input  ic_entry_pkg::ic_way_vec_t   debug_way,
   input  ic_entry_pkg::ic_tag_entry_t debug_wr_data,
   input  ic_entry_pkg::ic_way_vec_t   tag_valid,    // From external valid flops
   output logic                        rd_valid,
   output ic_entry_pkg::ic_way_vec_t   rd_hit,
   output ic_entry_pkg::ic_word_t      rd_data,
   output logic                        tag_perr
);

   ic_lookup_if u_lookup (.clk(clk));

   // Response follows the request by one cycle
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_en;
      end
   end

   ic_tag_array u_tag_array (
      .clk           (clk),
      .arst_n        (arst_n),
      .rw_addr       (rw_addr),
      .rd_en         (rd_en),
      .wr_en         (wr_en),
      .debug_wr_en   (debug_wr_en),
      .debug_way     (debug_way),
      .debug_wr_data (debug_wr_data),
      .lookup        (u_lookup.tag_src)
   );

   ic_data_array u_data_array (
      .clk     (clk),
      .rw_addr (rw_addr),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .lookup  (u_lookup.data_src)
   );

   ic_way_select u_way_select (
      .tag_valid (tag_valid),
      .lookup    (u_lookup.sel),
      .rd_hit    (rd_hit),
      .rd_data   (rd_data),
      .tag_perr  (tag_perr)
   );

   // Shared address port, so only one access kind per cycle
   a_one_access : assert property (
      @(posedge clk) disable iff (!arst_n) $onehot0({rd_en, |wr_en, debug_wr_en})
   ) else $error("ifu_ic_mem read, fill and debug write overlap");

endmodule

//--- sim/tb_ifu_ic_mem.sv
////////////////////////////////////////////////////////////
// Testbench for the instruction cache memory top
// Reference model of tags, parity and words with assertion checks
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

`include "ic_consts.svh"

module tb_ifu_ic_mem;

   import ic_addr_pkg::*;
   import ic_entry_pkg::*;

   localparam int SETS         = 1 << `IC_INDEX_BITS;
   localparam int RESP_TIMEOUT = 20;                   // Cycles to drain responses

   logic          clk;
   logic          arst_n;
   ic_addr_t      rw_addr;
   logic          rd_en;
   ic_way_vec_t   wr_en;
   ic_word_t      wr_data;
   logic          debug_wr_en;
   ic_way_vec_t   debug_way;
   ic_tag_entry_t debug_wr_data;
   ic_way_vec_t   tag_valid;
   logic          rd_valid;
   ic_way_vec_t   rd_hit;
   ic_word_t      rd_data;
   logic          tag_perr;

   // Reference model state
   ic_tag_entry_t model_tag [`IC_NUM_WAYS][SETS];
   ic_word_t      model_word [`IC_NUM_WAYS][SETS*4];
   ic_way_vec_t   model_valid [SETS];                  // External valid flops
   ic_way_vec_t   valid_mask;                          // Clears valid bits for one read
   ic_way_vec_t   next_tag_valid;
   ic_way_vec_t   exp_match_q;
   ic_way_vec_t   exp_perr_q;
   ic_word_t      exp_words_q [`IC_NUM_WAYS];
   ic_way_vec_t   exp_hit;
   ic_word_t      exp_data;
   logic          exp_perr;
   int            issued_count;
   int            checked_count;
   int            perr_seen;
   int            miss_seen;
   logic [31:0]   lcg_state;

   ifu_ic_mem uut (
      .clk           (clk),
      .arst_n        (arst_n),
      .rw_addr       (rw_addr),
      .rd_en         (rd_en),
      .wr_en         (wr_en),
      .wr_data       (wr_data),
      .debug_wr_en   (debug_wr_en),
      .debug_way     (debug_way),
      .debug_wr_data (debug_wr_data),
      .tag_valid     (tag_valid),
      .rd_valid      (rd_valid),
      .rd_hit        (rd_hit),
      .rd_data       (rd_data),
      .tag_perr      (tag_perr)
   );

   always #4 clk = ~clk;                               // 8 ns period

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "stopped on first error");
   endtask

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic idle_inputs();
      rd_en         = 1'b0;
      wr_en         = '0;
      wr_data       = '0;
      debug_wr_en   = 1'b0;
      debug_way     = '0;
      debug_wr_data = '0;
      valid_mask    = '0;
   endtask

   // Four beats with the tag on the last word
   task automatic fill_line(input int way, input ic_tag_t tag, input ic_index_t index);
      for (int w = 0; w < 4; w++) begin
         next_cycle();
         idle_inputs();
         rw_addr.tag      = tag;
         rw_addr.index    = index;
         rw_addr.word_sel = ic_word_sel_t'(w);
         wr_en            = ic_way_vec_t'(1) << way;
         wr_data          = next_random();
      end
   endtask

   task automatic read_word(input ic_tag_t tag, input ic_index_t index,
                            input ic_word_sel_t wsel, input ic_way_vec_t mask);
      next_cycle();
      idle_inputs();
      rw_addr.tag      = tag;
      rw_addr.index    = index;
      rw_addr.word_sel = wsel;
      rd_en            = 1'b1;
      valid_mask       = mask;
      issued_count++;
   endtask

   task automatic debug_write(input ic_index_t index, input ic_way_vec_t ways,
                              input ic_tag_entry_t entry);
      next_cycle();
      idle_inputs();
      rw_addr.index = index;
      debug_wr_en   = 1'b1;
      debug_way     = ways;
      debug_wr_data = entry;
   endtask

   task automatic wait_responses();
      int cycles;
      cycles = 0;
      while (checked_count != issued_count) begin
         next_cycle();
         cycles++;
         if (cycles > RESP_TIMEOUT) begin
            report_failure("Timeout waiting for read responses");
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      next_tag_valid = '0;
      if (rd_valid) begin                              // Response cycle ending now
         checked_count++;
         if (exp_perr) perr_seen++;
         if (exp_hit == '0) miss_seen++;
      end
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         if (wr_en[w]) begin
            model_word[w][{rw_addr.index, rw_addr.word_sel}] = wr_data;
            if (rw_addr.word_sel == 2'd3) begin
               model_tag[w][rw_addr.index]   = {^rw_addr.tag, rw_addr.tag};   // Even parity
               model_valid[rw_addr.index][w] = 1'b1;
            end
         end
         if (debug_wr_en && debug_way[w]) begin
            model_tag[w][rw_addr.index] = debug_wr_data;
         end
      end
      if (rd_en) begin
         for (int w = 0; w < `IC_NUM_WAYS; w++) begin
            exp_match_q[w] = (model_tag[w][rw_addr.index].tag == rw_addr.tag);
            exp_perr_q[w]  = ^model_tag[w][rw_addr.index];                   // Odd count is bad
            exp_words_q[w] = model_word[w][{rw_addr.index, rw_addr.word_sel}];
         end
         next_tag_valid = model_valid[rw_addr.index] & valid_mask;
      end
      #1;
      tag_valid = next_tag_valid;                      // Valid flops drive the response cycle
   end

   always_comb begin
      exp_hit  = exp_match_q & tag_valid;
      exp_data = '0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         if (exp_hit[w]) exp_data = exp_data | exp_words_q[w];
      end
      exp_perr = |(exp_perr_q & tag_valid);
   end

   ////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////

   a_reset_valid : assert property (@(posedge clk) !arst_n |-> !rd_valid)
      else report_failure($sformatf("FAILED rd_valid: got %h expected 0 in reset",
                                    $sampled(rd_valid)));

   a_valid_follow : assert property (@(posedge clk) disable iff (!arst_n) rd_en |=> rd_valid)
      else report_failure($sformatf("FAILED rd_valid: got %h expected 1",
                                    $sampled(rd_valid)));

   a_valid_idle : assert property (@(posedge clk) disable iff (!arst_n) !rd_en |=> !rd_valid)
      else report_failure($sformatf("FAILED rd_valid: got %h expected 0",
                                    $sampled(rd_valid)));

   a_hit : assert property (@(posedge clk) rd_valid |-> rd_hit == exp_hit)
      else report_failure($sformatf("FAILED rd_hit: got %h expected %h",
                                    $sampled(rd_hit), $sampled(exp_hit)));

   a_data : assert property (@(posedge clk) rd_valid |-> rd_data == exp_data)
      else report_failure($sformatf("FAILED rd_data: got %h expected %h",
                                    $sampled(rd_data), $sampled(exp_data)));

   a_perr : assert property (@(posedge clk) rd_valid |-> tag_perr == exp_perr)
      else report_failure($sformatf("FAILED tag_perr: got %h expected %h",
                                    $sampled(tag_perr), $sampled(exp_perr)));

   ////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0]   r;
      int            way_a;
      int            way_r;
      ic_index_t     idx_a;
      ic_index_t     idx_b;
      ic_tag_t       tag_a;
      ic_tag_t       set_tags [`IC_NUM_WAYS];
      ic_tag_entry_t bad_entry;

      lcg_state     = 32'h6d645ac5;
      clk           = 1'b0;
      arst_n        = 1'b1;
      rw_addr       = '0;
      tag_valid     = '0;
      idle_inputs();
      issued_count  = 0;
      checked_count = 0;
      perr_seen     = 0;
      miss_seen     = 0;
      exp_match_q   = '0;
      exp_perr_q    = '0;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         exp_words_q[w] = '0;
         for (int s = 0; s < SETS; s++) model_tag[w][s] = '0;
         for (int s = 0; s < SETS*4; s++) model_word[w][s] = '0;
      end
      for (int s = 0; s < SETS; s++) model_valid[s] = '0;

      #1 arst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1 arst_n = 1'b1;

      // One line into one way and every word of it read back
      r     = next_random();
      way_a = int'(r[31:30]);
      idx_a = r[29:24];
      r     = next_random();
      tag_a = r[31:10];
      fill_line(way_a, tag_a, idx_a);
      for (int w = 0; w < 4; w++) read_word(tag_a, idx_a, ic_word_sel_t'(w), '1);

      // Full set with distinct tags and back-to-back random reads
      idx_b = idx_a ^ 6'h20;
      for (int w = 0; w < `IC_NUM_WAYS; w++) begin
         r           = next_random();
         set_tags[w] = {r[31:12], w[1:0]};             // Low bits keep tags apart
         fill_line(w, set_tags[w], idx_b);
      end
      for (int n = 0; n < 16; n++) begin
         r     = next_random();
         way_r = int'(r[31:30]);
         read_word(set_tags[way_r], idx_b, r[29:28], '1);
      end

      // Misses on an unknown tag and on an invalid way
      read_word(set_tags[0] ^ ic_tag_t'(4), idx_b, 2'd0, '1);
      read_word(set_tags[2], idx_b, 2'd1, 4'b1011);

      // Bad parity stored on purpose in way 1
      bad_entry.tag    = set_tags[1];
      bad_entry.parity = ~(^set_tags[1]);
      debug_write(idx_b, 4'b0010, bad_entry);
      read_word(set_tags[1], idx_b, 2'd3, '1);
      read_word(set_tags[1], idx_b, 2'd3, 4'b1101);

      next_cycle();
      idle_inputs();
      wait_responses();

      if (perr_seen > 0 && miss_seen > 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         report_failure("Stimulus did not reach the parity error and miss responses");
      end
   end

endmodule

//--- ifu_ic_mem.f
+incdir+common
common/ic_addr_pkg.sv
common/ic_entry_pkg.sv
common/ic_lookup_if.sv
design/ic_sram.sv
ic_tag/ic_tag_array.sv
ic_data/ic_data_array.sv
design/ic_way_select.sv
design/ifu_ic_mem.sv
sim/tb_ifu_ic_mem.sv

//--- Makefile
# Verilator build for the instruction cache memory

TB_TOP  := tb_ifu_ic_mem
RTL_TOP := ifu_ic_mem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f ifu_ic_mem.f \
		--top-module $(TB_TOP) -o V$(TB_TOP)

# Pass only when the simulation prints the pass message
run: build
	@out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing -f ifu_ic_mem.f --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir
